// File: include/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ========================================
// Load/store unit widths
// ========================================

`define LSU_XLEN        32      // Data word and address width
`define LSU_RD_W        5       // Destination register tag
`define LSU_F3_W        3       // funct3 field width

// ========================================
// Byte lane geometry and encodings
// ========================================

`define LSU_MASK_W      4       // Byte lanes per word
`define LSU_OFS_W       2       // Byte offset within a word
`define LSU_F3_SIGN_BIT 2       // Set for LBU/LHU

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_lsu -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_lsu)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: tests/tb_clock.sv
module tb_clock (
    output logic o_clk,     // Testbench clock, period 40
    output logic o_rst      // Sync reset, high for 4 cycles
);

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;     // Half period 20
    end

    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clk);
        o_rst <= 1'b0;                  // Released on a rising edge
    end

endmodule

// File: tests/tb_lsu.sv
`include "lsu_settings.svh"

module tb_lsu;

    // ========================================
    // Run length and timeout
    // ========================================

    localparam int N_BP      = 64;                          // Accesses under back-pressure
    localparam int T_STORE   = 7 + 3;
    localparam int T_LOAD    = 4 + 52 + 4;
    localparam int T_FWD     = 16 + 3;
    localparam int T_MIS     = 24 + 3;
    localparam int T_BP      = N_BP * 4 + 4;                // Four cycles per stalled access
    localparam int STIM_LEN  = 8 + T_STORE + T_LOAD + T_FWD + T_MIS + T_BP;
    localparam int LIMIT     = 2 * STIM_LEN;

    logic                    clk;
    logic                    rst;
    logic                    i_valid;
    logic                    i_load;
    logic                    i_store;
    logic [`LSU_F3_W-1:0]    i_funct3;
    logic [`LSU_XLEN-1:0]    i_addr;
    logic [`LSU_XLEN-1:0]    i_store_data;
    logic [`LSU_RD_W-1:0]    i_rd;
    logic [`LSU_XLEN-1:0]    i_dmem_rdata;
    logic                    i_dmem_ready;
    logic                    o_stall;
    logic [`LSU_XLEN-1:0]    o_dmem_addr;
    logic                    o_dmem_ren;
    logic                    o_dmem_wen;
    logic [`LSU_MASK_W-1:0]  o_dmem_mask;
    logic [`LSU_XLEN-1:0]    o_dmem_wdata;
    logic                    o_valid;
    logic                    o_load;
    logic [`LSU_RD_W-1:0]    o_rd;
    logic [`LSU_XLEN-1:0]    o_load_data;
    logic                    o_misaligned;

    tb_clock clock_i (.o_clk(clk), .o_rst(rst));

    lsu_top dut_i (
        .i_clk(clk), .i_rst(rst), .i_valid(i_valid), .i_load(i_load),
        .i_store(i_store), .i_funct3(i_funct3), .i_addr(i_addr),
        .i_store_data(i_store_data), .i_rd(i_rd), .o_stall(o_stall),
        .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen),
        .o_dmem_mask(o_dmem_mask), .o_dmem_wdata(o_dmem_wdata),
        .i_dmem_rdata(i_dmem_rdata), .i_dmem_ready(i_dmem_ready),
        .o_valid(o_valid), .o_load(o_load), .o_rd(o_rd),
        .o_load_data(o_load_data), .o_misaligned(o_misaligned)
    );

    // ========================================
    // Model memory with one edge of write delay
    // ========================================

    logic [31:0] mem [64];
    logic        pend_v;
    logic [5:0]  pend_idx;
    logic [3:0]  pend_mask;
    logic [31:0] pend_data;
    logic [7:0]  ref_img [256];                 // Byte image in program order
    logic [31:0] lfsr;
    logic        bp_mode;                       // Random ready when set
    int          errors;
    int          err_mark;
    int          passed;
    int          failed;
    int          accepted;
    int          completed;
    int          cycles;

    assign i_dmem_rdata = mem[o_dmem_addr[7:2]];    // Combinational read

    always @(posedge clk) begin
        if (pend_v) begin
            for (int l = 0; l < 4; l++) begin
                if (pend_mask[l]) mem[pend_idx][8*l +: 8] <= pend_data[8*l +: 8];
            end
        end
        pend_v    <= o_dmem_wen & i_dmem_ready;     // Commit needs ready
        pend_idx  <= o_dmem_addr[7:2];
        pend_mask <= o_dmem_mask;
        pend_data <= o_dmem_wdata;
    end

    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) * 32'h0107_0b0d) ^ 32'h5a3c_c3a5;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);   // Taps 32 22 2 1
    endfunction

    function logic [31:0] draw_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};              // One step per bit
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // ========================================
    // Expected values from the access rules
    // ========================================

    function automatic logic [3:0] mask_for_access(input logic [2:0] f3, input logic [1:0] off);
        case (f3[1:0])
            2'b00:   return 4'b0001 << off;
            2'b01:   return 4'b0011 << off;
            default: return 4'b1111 << off;         // Lanes past 3 are lost
        endcase
    endfunction

    function automatic logic [31:0] predict_load(input logic [2:0] f3, input logic [7:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        logic        ext;
        b = ref_img[a];
        h = {ref_img[{a[7:2], a[1], 1'b1}], ref_img[{a[7:2], a[1], 1'b0}]};
        case (f3[1:0])
            2'b00: begin
                ext = ~f3[2] & b[7];
                return {{24{ext}}, b};
            end
            2'b01: begin
                ext = ~f3[2] & h[15];
                return {{16{ext}}, h};
            end
            default: return {ref_img[{a[7:2], 2'd3}], ref_img[{a[7:2], 2'd2}],
                             ref_img[{a[7:2], 2'd1}], ref_img[{a[7:2], 2'd0}]};
        endcase
    endfunction

    logic        exp_valid;
    logic        exp_load;
    logic        exp_store;
    logic [31:0] exp_addr;
    logic [3:0]  exp_mask;
    logic [31:0] exp_wdata;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_mis;
    logic        exp_stall;

    // Held access waits while memory is not ready
    assign exp_stall = exp_valid && (exp_load || exp_store) && !i_dmem_ready;

    always @(posedge clk) begin
        logic [3:0] m;
        logic [31:0] wd;
        m  = mask_for_access(i_funct3, i_addr[1:0]);
        wd = i_store_data << {i_addr[1:0], 3'b000};     // Eight bits per byte offset
        if (rst) begin
            exp_valid <= 1'b0;
        end else begin
            if (o_valid && !o_stall) completed++;       // Result leaves the unit
            if (!exp_stall) begin
                exp_valid <= i_valid;
                if (i_valid) begin
                    accepted++;
                    exp_load  <= i_load;
                    exp_store <= i_store;
                    exp_addr  <= {i_addr[31:2], 2'b00};
                    exp_mask  <= m;
                    exp_wdata <= wd;
                    exp_rd    <= i_rd;
                    exp_data  <= predict_load(i_funct3, i_addr[7:0]);
                    exp_mis   <= ((i_funct3[1:0] == 2'b01) && i_addr[0]) ||
                                 (i_funct3[1] && (i_addr[1:0] != 2'b00));
                    if (i_store) begin
                        for (int l = 0; l < 4; l++) begin
                            if (m[l]) ref_img[{i_addr[7:2], 2'(l)}] = wd[8*l +: 8];
                        end
                    end
                end
            end
        end
    end

    logic        rst_q;
    logic        stall_q;
    logic [31:0] hold_data;
    logic [31:0] hold_wdata;
    logic [4:0]  hold_rd;

    always @(posedge clk) begin
        rst_q      <= rst;
        stall_q    <= o_stall;
        hold_data  <= o_load_data;                  // Last cycle's outputs
        hold_wdata <= o_dmem_wdata;
        hold_rd    <= o_rd;
    end

    // ========================================
    // Output checks
    // ========================================

    a_reset: assert property (@(posedge clk)
        rst_q |-> (!o_valid && !o_dmem_ren && !o_dmem_wen && !o_stall))
        else log_error($sformatf(
            "ERROR o_valid/o_dmem_ren/o_dmem_wen/o_stall %h/%h/%h/%h exp 0/0/0/0",
            $sampled(o_valid), $sampled(o_dmem_ren), $sampled(o_dmem_wen),
            $sampled(o_stall)));
    a_valid: assert property (@(posedge clk) disable iff (rst) o_valid == exp_valid)
        else log_error($sformatf("ERROR o_valid %h exp %h", $sampled(o_valid),
            $sampled(exp_valid)));
    a_load: assert property (@(posedge clk) disable iff (rst) exp_valid |-> o_load == exp_load)
        else log_error($sformatf("ERROR o_load %h exp %h", $sampled(o_load),
            $sampled(exp_load)));
    a_stall: assert property (@(posedge clk) disable iff (rst) o_stall == exp_stall)
        else log_error($sformatf("ERROR o_stall %h exp %h", $sampled(o_stall),
            $sampled(exp_stall)));
    a_addr: assert property (@(posedge clk) disable iff (rst) exp_valid |-> o_dmem_addr == exp_addr)
        else log_error($sformatf("ERROR o_dmem_addr %h exp %h", $sampled(o_dmem_addr),
            $sampled(exp_addr)));
    a_ren: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> (o_dmem_ren == exp_load && o_dmem_wen == exp_store))
        else log_error($sformatf("ERROR o_dmem_ren/o_dmem_wen %h/%h exp %h/%h",
            $sampled(o_dmem_ren), $sampled(o_dmem_wen), $sampled(exp_load),
            $sampled(exp_store)));
    a_mask: assert property (@(posedge clk) disable iff (rst)
        (exp_valid && exp_store) |-> o_dmem_mask == exp_mask)
        else log_error($sformatf("ERROR o_dmem_mask %h exp %h", $sampled(o_dmem_mask),
            $sampled(exp_mask)));
    a_wdata: assert property (@(posedge clk) disable iff (rst)
        (exp_valid && exp_store) |-> o_dmem_wdata == exp_wdata)
        else log_error($sformatf("ERROR o_dmem_wdata %h exp %h", $sampled(o_dmem_wdata),
            $sampled(exp_wdata)));
    a_rd: assert property (@(posedge clk) disable iff (rst) exp_valid |-> o_rd == exp_rd)
        else log_error($sformatf("ERROR o_rd %h exp %h", $sampled(o_rd),
            $sampled(exp_rd)));
    a_ldata: assert property (@(posedge clk) disable iff (rst)
        (exp_valid && exp_load) |-> o_load_data == exp_data)
        else log_error($sformatf("ERROR o_load_data %h exp %h", $sampled(o_load_data),
            $sampled(exp_data)));
    a_mis: assert property (@(posedge clk) disable iff (rst) exp_valid |-> o_misaligned == exp_mis)
        else log_error($sformatf("ERROR o_misaligned %h exp %h", $sampled(o_misaligned),
            $sampled(exp_mis)));
    // Load data only counts for a held load
    a_hold: assert property (@(posedge clk) disable iff (rst)
        stall_q |-> ((!exp_load || o_load_data == hold_data) &&
                     o_dmem_wdata == hold_wdata && o_rd == hold_rd))
        else log_error($sformatf(
            "ERROR o_load_data/o_dmem_wdata/o_rd %h/%h/%h held %h/%h/%h in stall",
            $sampled(o_load_data), $sampled(o_dmem_wdata), $sampled(o_rd),
            $sampled(hold_data), $sampled(hold_wdata), $sampled(hold_rd)));

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic drive_ready();
        if (bp_mode) i_dmem_ready <= (draw_bits(2) != 32'd0);  // Low one cycle in four
        else         i_dmem_ready <= 1'b1;
    endtask

    // Starts at a rising edge and returns at the accepting edge
    task automatic issue_access(input logic ld, input logic [2:0] f3,
                                input logic [5:0] w, input logic [1:0] off);
        logic took;
        i_valid      <= 1'b1;
        i_load       <= ld;
        i_store      <= ~ld;
        i_funct3     <= f3;
        i_addr       <= {24'h0, w, off};
        i_store_data <= draw_bits(32);
        i_rd         <= 5'(draw_bits(5));
        do begin
            @(negedge clk);
            took = ~o_stall;                        // Stable between edges
            @(posedge clk);
            drive_ready();
        end while (!took);
    endtask

    task automatic idle_cycles(input int n);
        i_valid <= 1'b0;
        repeat (n) begin
            @(posedge clk);
            drive_ready();
        end
    endtask

    task automatic report_test(input string name);
        if (errors == err_mark) begin
            passed++;
            $display("test %-10s ok", name);
        end else begin
            failed++;
            $display("test %-10s failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        logic [1:0]  sz;
        logic [1:0]  off;
        logic [5:0]  w;
        logic [31:0] fw;
        i_valid      = 1'b0;
        i_load       = 1'b0;
        i_store      = 1'b0;
        i_funct3     = '0;
        i_addr       = '0;
        i_store_data = '0;
        i_rd         = '0;
        i_dmem_ready = 1'b1;
        lfsr         = 32'ha2b3_5a37;
        bp_mode      = 1'b0;
        pend_v       = 1'b0;
        errors       = 0;
        err_mark     = 0;
        passed       = 0;
        failed       = 0;
        accepted     = 0;
        completed    = 0;
        cycles       = 0;
        for (int i = 0; i < 64; i++) begin
            fw     = fill_word(i);
            mem[i] = fw;
            for (int l = 0; l < 4; l++) ref_img[4*i + l] = fw[8*l +: 8];
        end
        @(posedge clk);
        while (rst) @(posedge clk);                 // First edge after release
        idle_cycles(2);
        report_test("reset");

        // SB at 4 offsets, SH at 2, SW at 1
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o += (1 << s)) begin
                issue_access(1'b0, 3'(s), 6'(draw_bits(6)), 2'(o));
            end
        end
        idle_cycles(2);
        report_test("store_enc");

        for (int k = 0; k < 4; k++) issue_access(1'b0, 3'd2, 6'(32 + k), 2'd0);
        idle_cycles(3);                             // Let the writes commit
        for (int k = 0; k < 4; k++) begin
            for (int f = 0; f < 6; f++) begin
                if (f != 3) begin
                    for (int o = 0; o < 4; o += (1 << (f & 3))) begin
                        issue_access(1'b1, 3'(f), 6'(32 + k), 2'(o));
                    end
                end
            end
        end
        idle_cycles(2);
        report_test("load_fmt");

        for (int k = 0; k < 8; k++) begin
            sz  = 2'(draw_bits(2));
            if (sz == 2'd3) sz = 2'd2;
            off = 2'(draw_bits(2)) & ~((2'd1 << sz) - 2'd1);    // Aligned offset
            w   = 6'(draw_bits(6));
            issue_access(1'b0, {1'b0, sz}, w, off);
            issue_access(1'b1, 3'd2, w, 2'd0);      // Same word right behind
        end
        idle_cycles(2);
        report_test("forward");

        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o++) begin
                issue_access(1'b0, 3'(s), 6'(48 + o), 2'(o));
                issue_access(1'b1, 3'(s), 6'(48 + o), 2'(o));
            end
        end
        idle_cycles(2);
        report_test("misalign");

        bp_mode = 1'b1;
        for (int k = 0; k < N_BP; k++) begin
            sz  = 2'(draw_bits(2));
            if (sz == 2'd3) sz = 2'd2;
            off = 2'(draw_bits(2)) & ~((2'd1 << sz) - 2'd1);
            issue_access(draw_bits(1) != 0, {1'b0, sz}, 6'(draw_bits(3)), off);  // Few words
        end
        bp_mode = 1'b0;
        idle_cycles(3);
        assert (accepted == completed)
            else begin
                errors++;
                $display("access count mismatch: %0d accepted but %0d completed",
                         accepted, completed);
            end
        report_test("backpress");

        $display("tests %0d passed %0d failed %0d errors %0d accesses %0d",
                 passed + failed, passed, failed, errors, accepted);
        if (errors == 0 && failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_access.sv
verilog/lsu_result.sv
verilog/lsu_top.sv
tests/tb_clock.sv
tests/tb_lsu.sv

// File: verilog/lsu_access.sv
`include "lsu_settings.svh"

module lsu_access
    import lsu_pkg::*;
(
    input  logic                    i_clk,          // Core clock
    input  logic                    i_rst,          // Sync reset, active high
    input  logic                    i_dmem_ready,   // Access completes this cycle
    input  logic [`LSU_XLEN-1:0]    i_dmem_rdata,   // Same-cycle read data
    input  logic                    i_acc_valid,    // Held access valid
    input  logic                    i_acc_load,     // Held access is a load
    input  logic                    i_acc_store,    // Held access is a store
    input  logic [`LSU_XLEN-1:0]    i_acc_addr,     // Word aligned address
    input  logic [`LSU_OFS_W-1:0]   i_acc_offset,   // Byte offset
    input  logic [`LSU_MASK_W-1:0]  i_acc_mask,     // Byte enables
    input  logic [`LSU_XLEN-1:0]    i_acc_data,     // Store data, lane 0 based
    output logic [`LSU_XLEN-1:0]    o_dmem_addr,    // Word aligned
    output logic                    o_dmem_ren,     // Read strobe
    output logic                    o_dmem_wen,     // Write strobe
    output logic [`LSU_MASK_W-1:0]  o_dmem_mask,    // Write byte enables
    output logic [`LSU_XLEN-1:0]    o_dmem_wdata,   // Lane shifted store data
    output mem_word_u               o_read_word     // Read word after forwarding
);

    // ========================================
    // Memory port
    // ========================================

    logic [`LSU_XLEN-1:0]   wdata;
    logic                   ren;
    logic                   wen;
    logic                   write_done;             // Store commits at this edge

    assign ren        = i_acc_valid & i_acc_load;
    assign wen        = i_acc_valid & i_acc_store;
    assign wdata      = i_acc_data << {i_acc_offset, 3'b000}; // 8 bits per offset step
    assign write_done = wen & i_dmem_ready;

    assign o_dmem_addr  = i_acc_addr;
    assign o_dmem_ren   = ren;
    assign o_dmem_wen   = wen;
    assign o_dmem_mask  = i_acc_mask;
    assign o_dmem_wdata = wdata;

    // ========================================
    // Store record for forwarding
    // ========================================

    // Memory shows a written word only one edge after commit
    logic                   rec_valid;
    logic [`LSU_XLEN-1:0]   rec_addr;
    logic [`LSU_MASK_W-1:0] rec_mask;
    mem_word_u              rec_data;               // Already lane shifted
    logic                   fwd_hit;
    mem_word_u              raw_word;
    mem_word_u              merged_word;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rec_valid <= 1'b0;
        end else if (write_done) begin
            rec_valid <= 1'b1;                      // Stays until next store
        end
    end

    always_ff @(posedge i_clk) begin
        if (write_done) begin
            rec_addr <= i_acc_addr;
            rec_mask <= i_acc_mask;
            rec_data <= wdata;
        end
    end

    // Same word as the last completed store
    assign fwd_hit  = ren & rec_valid & (rec_addr == i_acc_addr);
    assign raw_word = i_dmem_rdata;

    always_comb begin
        merged_word = raw_word;
        for (int lane = 0; lane < `LSU_MASK_W; lane++) begin
            if (fwd_hit && rec_mask[lane]) begin    // Recorded byte wins
                merged_word.bytes[lane] = rec_data.bytes[lane];
            end
        end
    end

    assign o_read_word = merged_word;

endmodule

// File: verilog/lsu_decode.sv
`include "lsu_settings.svh"

module lsu_decode
    import lsu_pkg::*;
(
    input  logic                    i_clk,          // Core clock
    input  logic                    i_rst,          // Sync reset, active high
    input  logic                    i_valid,        // Access offered by execute
    input  logic                    i_load,         // Load instruction
    input  logic                    i_store,        // Store instruction
    input  logic [`LSU_F3_W-1:0]    i_funct3,       // Size and signedness
    input  logic [`LSU_XLEN-1:0]    i_addr,         // rs1 + imm, unaligned
    input  logic [`LSU_XLEN-1:0]    i_store_data,   // rs2 value for stores
    input  logic [`LSU_RD_W-1:0]    i_rd,           // Destination tag
    input  logic                    i_dmem_ready,   // Memory can finish access
    output logic                    o_stall,        // Hold upstream inputs
    output logic                    o_acc_valid,    // Held access valid
    output logic                    o_acc_load,     // Held access is a load
    output logic                    o_acc_store,    // Held access is a store
    output logic [`LSU_XLEN-1:0]    o_acc_addr,     // Word aligned address
    output logic [`LSU_OFS_W-1:0]   o_acc_offset,   // Byte within the word
    output logic [`LSU_MASK_W-1:0]  o_acc_mask,     // Byte enables
    output logic [`LSU_XLEN-1:0]    o_acc_data,     // Unshifted store data
    output lsu_size_e               o_acc_size,     // Decoded size
    output logic                    o_acc_unsigned, // Zero extend on load
    output logic [`LSU_RD_W-1:0]    o_acc_rd,       // Destination tag
    output logic                    o_misaligned    // Half/word off boundary
);

    // ========================================
    // Stage register
    // ========================================

    logic                   acc_valid;
    logic                   acc_load;
    logic                   acc_store;
    logic [`LSU_XLEN-1:0]   acc_addr;                   // Full address incl offset
    logic [`LSU_XLEN-1:0]   acc_data;
    logic [`LSU_F3_W-1:0]   acc_funct3;
    logic [`LSU_RD_W-1:0]   acc_rd;
    logic                   stall;
    logic                   accept;
    logic [`LSU_OFS_W-1:0]  offset;
    lsu_size_e              size;
    logic [`LSU_MASK_W-1:0] size_pattern;               // Mask before offset shift

    // Memory busy on a real access
    assign stall  = acc_valid & (acc_load | acc_store) & ~i_dmem_ready;
    assign accept = i_valid & ~stall;                   // Takes the new access

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            acc_valid <= 1'b0;
            acc_load  <= 1'b0;
            acc_store <= 1'b0;
        end else if (!stall) begin                      // Bubble if nothing offered
            acc_valid <= i_valid;
            acc_load  <= i_valid & i_load;
            acc_store <= i_valid & i_store;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin                               // Payload held under stall
            acc_addr   <= i_addr;
            acc_data   <= i_store_data;
            acc_funct3 <= i_funct3;
            acc_rd     <= i_rd;
        end
    end

    // ========================================
    // Access decode
    // ========================================

    assign offset = acc_addr[`LSU_OFS_W-1:0];

    always_comb begin
        case (acc_funct3[1:0])
            2'b00:   size = BYTE;
            2'b01:   size = HALF;
            default: size = WORD;                       // 2'b11 falls back to word
        endcase
    end

    always_comb begin
        case (size)
            BYTE:    size_pattern = `LSU_MASK_W'(1);    // 0001
            HALF:    size_pattern = `LSU_MASK_W'(3);    // 0011
            default: size_pattern = {`LSU_MASK_W{1'b1}};
        endcase
    end

    // Only reported, the access still goes out
    assign o_misaligned = acc_valid & (acc_load | acc_store) &
                          (((size == HALF) & offset[0]) |
                           ((size == WORD) & (offset != '0)));

    assign o_stall        = stall;
    assign o_acc_valid    = acc_valid;
    assign o_acc_load     = acc_load;
    assign o_acc_store    = acc_store;
    assign o_acc_addr     = {acc_addr[`LSU_XLEN-1:`LSU_OFS_W], {`LSU_OFS_W{1'b0}}};
    assign o_acc_offset   = offset;
    assign o_acc_mask     = size_pattern << offset; // Upper lanes drop off the top
    assign o_acc_data     = acc_data;
    assign o_acc_size     = size;
    assign o_acc_unsigned = acc_funct3[`LSU_F3_SIGN_BIT];
    assign o_acc_rd       = acc_rd;

endmodule

// File: verilog/lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

    // ========================================
    // Access size, from funct3[1:0]
    // ========================================

    typedef enum logic [1:0] {
        BYTE = 2'b00,                           // LB/LBU/SB
        HALF = 2'b01,                           // LH/LHU/SH
        WORD = 2'b10                            // LW/SW, also the fallback
    } lsu_size_e;

    // ========================================
    // Memory word with two lane views
    // ========================================

    // Byte view for lane merges, halfword view for LH/LHU selection
    typedef union packed {
        logic [`LSU_MASK_W-1:0][7:0]     bytes;  // Lane 0 is the low byte
        logic [`LSU_MASK_W/2-1:0][15:0]  halves; // Half 1 is the upper 16 bits
    } mem_word_u;

endpackage

// File: verilog/lsu_result.sv
`include "lsu_settings.svh"

module lsu_result
    import lsu_pkg::*;
(
    input  mem_word_u               i_read_word,    // Forwarded read word
    input  lsu_size_e               i_acc_size,     // Access size
    input  logic                    i_acc_unsigned, // Zero extend
    input  logic [`LSU_OFS_W-1:0]   i_acc_offset,   // Byte offset
    input  logic                    i_acc_valid,    // Held access valid
    input  logic                    i_acc_load,     // Held access is a load
    input  logic [`LSU_RD_W-1:0]    i_acc_rd,       // Destination tag
    input  logic                    i_misaligned,   // From decode
    output logic                    o_valid,        // Result cycle valid
    output logic                    o_load,         // Result is a load
    output logic [`LSU_RD_W-1:0]    o_rd,           // Tag for writeback
    output logic [`LSU_XLEN-1:0]    o_load_data,    // Extended load value
    output logic                    o_misaligned    // Misaligned access flag
);

    // ========================================
    // Lane select and extension
    // ========================================

    logic [7:0]             lane_byte;
    logic [15:0]            lane_half;
    logic                   ext_byte;           // Fill bit for byte loads
    logic                   ext_half;           // Fill bit for halfword loads
    logic [`LSU_XLEN-1:0]   load_data;

    assign lane_byte = i_read_word.bytes[i_acc_offset];
    assign lane_half = i_read_word.halves[i_acc_offset[`LSU_OFS_W-1]]; // Upper bit picks

    assign ext_byte = ~i_acc_unsigned & lane_byte[7];
    assign ext_half = ~i_acc_unsigned & lane_half[15];

    always_comb begin
        case (i_acc_size)
            BYTE:    load_data = {{(`LSU_XLEN-8){ext_byte}}, lane_byte};
            HALF:    load_data = {{(`LSU_XLEN-16){ext_half}}, lane_half};
            default: load_data = i_read_word;   // LW and unlisted funct3
        endcase
    end

    // ========================================
    // Result fields
    // ========================================

    assign o_valid      = i_acc_valid;
    assign o_load       = i_acc_load;
    assign o_rd         = i_acc_rd;
    assign o_load_data  = load_data;
    assign o_misaligned = i_misaligned;

endmodule

// File: verilog/lsu_top.sv
`include "lsu_settings.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                    i_clk,          // Core clock
    input  logic                    i_rst,          // Sync reset, active high
    input  logic                    i_valid,        // Access from execute
    input  logic                    i_load,         // Load instruction
    input  logic                    i_store,        // Store instruction
    input  logic [`LSU_F3_W-1:0]    i_funct3,       // Size and signedness
    input  logic [`LSU_XLEN-1:0]    i_addr,         // rs1 + imm
    input  logic [`LSU_XLEN-1:0]    i_store_data,   // rs2 value
    input  logic [`LSU_RD_W-1:0]    i_rd,           // Destination tag
    output logic                    o_stall,        // Upstream must hold
    output logic [`LSU_XLEN-1:0]    o_dmem_addr,    // Word aligned address
    output logic                    o_dmem_ren,     // Read strobe
    output logic                    o_dmem_wen,     // Write strobe
    output logic [`LSU_MASK_W-1:0]  o_dmem_mask,    // Byte enables
    output logic [`LSU_XLEN-1:0]    o_dmem_wdata,   // Shifted store data
    input  logic [`LSU_XLEN-1:0]    i_dmem_rdata,   // Same-cycle read data
    input  logic                    i_dmem_ready,   // Memory ready
    output logic                    o_valid,        // Result valid
    output logic                    o_load,         // Result is a load
    output logic [`LSU_RD_W-1:0]    o_rd,           // Result tag
    output logic [`LSU_XLEN-1:0]    o_load_data,    // Formatted load data
    output logic                    o_misaligned    // Misaligned flag
);

    // ========================================
    // Stage to stage wiring
    // ========================================

    logic                   acc_valid;
    logic                   acc_load;
    logic                   acc_store;
    logic [`LSU_XLEN-1:0]   acc_addr;
    logic [`LSU_OFS_W-1:0]  acc_offset;
    logic [`LSU_MASK_W-1:0] acc_mask;
    logic [`LSU_XLEN-1:0]   acc_data;
    lsu_size_e              acc_size;
    logic                   acc_unsigned;
    logic [`LSU_RD_W-1:0]   acc_rd;
    logic                   acc_misaligned;
    mem_word_u              read_word;          // After store forwarding

    lsu_decode decode_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_load         (i_load),
        .i_store        (i_store),
        .i_funct3       (i_funct3),
        .i_addr         (i_addr),
        .i_store_data   (i_store_data),
        .i_rd           (i_rd),
        .i_dmem_ready   (i_dmem_ready),
        .o_stall        (o_stall),
        .o_acc_valid    (acc_valid),
        .o_acc_load     (acc_load),
        .o_acc_store    (acc_store),
        .o_acc_addr     (acc_addr),
        .o_acc_offset   (acc_offset),
        .o_acc_mask     (acc_mask),
        .o_acc_data     (acc_data),
        .o_acc_size     (acc_size),
        .o_acc_unsigned (acc_unsigned),
        .o_acc_rd       (acc_rd),
        .o_misaligned   (acc_misaligned)
    );

    lsu_access access_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_dmem_ready   (i_dmem_ready),
        .i_dmem_rdata   (i_dmem_rdata),
        .i_acc_valid    (acc_valid),
        .i_acc_load     (acc_load),
        .i_acc_store    (acc_store),
        .i_acc_addr     (acc_addr),
        .i_acc_offset   (acc_offset),
        .i_acc_mask     (acc_mask),
        .i_acc_data     (acc_data),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_ren     (o_dmem_ren),
        .o_dmem_wen     (o_dmem_wen),
        .o_dmem_mask    (o_dmem_mask),
        .o_dmem_wdata   (o_dmem_wdata),
        .o_read_word    (read_word)
    );

    lsu_result result_i (
        .i_read_word    (read_word),
        .i_acc_size     (acc_size),
        .i_acc_unsigned (acc_unsigned),
        .i_acc_offset   (acc_offset),
        .i_acc_valid    (acc_valid),
        .i_acc_load     (acc_load),
        .i_acc_rd       (acc_rd),
        .i_misaligned   (acc_misaligned),
        .o_valid        (o_valid),
        .o_load         (o_load),
        .o_rd           (o_rd),
        .o_load_data    (o_load_data),
        .o_misaligned   (o_misaligned)
    );

endmodule
